// File: logic/heap_defs.svh
`ifndef HEAP_DEFS_SVH
`define HEAP_DEFS_SVH

// --------------------------------------------------
// heap geometry
// --------------------------------------------------

// one block is the allocation granule
`define HEAP_BLOCK_BYTES 64
`define HEAP_BLOCKS_PER_PAGE 8
// 16 pages, 128 blocks in total
`define HEAP_PAGE_COUNT 16

// a bitmap word covers four pages
`define HEAP_BITMAP_WORD_BITS 32

// byte address of block 0
`define HEAP_DATA_BASE 32'h0001_0000

// deep enough for every block in one class
`define HEAP_QUEUE_DEPTH 128

`endif

// File: logic/heap_pkg.sv
`include "heap_defs.svh"

package heap_pkg;

    typedef enum logic [1:0] {
        CLASS_1,
        CLASS_2,
        CLASS_4,
        CLASS_PAGE
    } size_class_t;

    typedef logic [6:0] block_idx_t;

    // bit set means the block is free
    typedef logic [`HEAP_BITMAP_WORD_BITS-1:0] bitmap_word_t;

    typedef logic [1:0] bitmap_addr_t;

    // smallest class that holds the byte count
    function automatic size_class_t class_of_bytes(input logic [15:0] bytes,
                                                   output logic oversize);
        oversize = 1'b0;
        if (bytes <= `HEAP_BLOCK_BYTES) begin
            return CLASS_1;
        end else if (bytes <= 2 * `HEAP_BLOCK_BYTES) begin
            return CLASS_2;
        end else if (bytes <= 4 * `HEAP_BLOCK_BYTES) begin
            return CLASS_4;
        end
        oversize = bytes > 8 * `HEAP_BLOCK_BYTES;
        return CLASS_PAGE;
    endfunction

    function automatic logic [3:0] blocks_of_class(input size_class_t c);
        return 4'd1 << c;
    endfunction

endpackage

// File: logic/class_queues.sv
`timescale 1ns/1ps
`include "heap_defs.svh"

module class_queues (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  heap_pkg::size_class_t push_class,
    input  heap_pkg::block_idx_t  push_block,
    input  logic                  pop,
    input  heap_pkg::size_class_t pop_class,
    output heap_pkg::block_idx_t  pop_block,
    output logic [3:0]            nonempty
);
    import heap_pkg::*;

    localparam int PTR_W = $clog2(`HEAP_QUEUE_DEPTH);

    block_idx_t head [4];

    // one circular buffer per size class
    for (genvar c = 0; c < 4; c++) begin : g_queue
        block_idx_t       mem [`HEAP_QUEUE_DEPTH];
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W:0]   count;
        logic             do_push;
        logic             do_pop;

        assign do_push = push && push_class == size_class_t'(c)
                         && count != `HEAP_QUEUE_DEPTH;
        // popping an empty queue does nothing
        assign do_pop = pop && pop_class == size_class_t'(c) && count != 0;

        assign head[c] = mem[rd_ptr];
        assign nonempty[c] = count != 0;

        always_ff @(posedge clk) begin
            if (rst) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count <= '0;
            end else begin
                if (do_push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (do_pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                if (do_push && !do_pop) begin
                    count <= count + 1'b1;
                end else if (do_pop && !do_push) begin
                    count <= count - 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (do_push) begin
                mem[wr_ptr] <= push_block;
            end
        end
    end

    assign pop_block = head[pop_class];

endmodule

// File: logic/bitmap_arbiter.sv
`timescale 1ns/1ps
`include "heap_defs.svh"

module bitmap_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc_req,
    output logic                   alloc_ack,
    input  logic                   free_req,
    output logic                   free_ack,
    input  heap_pkg::bitmap_addr_t alloc_bm_addr,
    input  heap_pkg::bitmap_addr_t free_bm_addr,
    input  logic                   alloc_bm_we,
    input  logic                   free_bm_we,
    input  heap_pkg::bitmap_word_t alloc_bm_wdata,
    input  heap_pkg::bitmap_word_t free_bm_wdata,
    output heap_pkg::bitmap_word_t bm_rdata,
    input  logic                   alloc_q_push,
    input  logic                   free_q_push,
    input  heap_pkg::size_class_t  alloc_q_class,
    input  heap_pkg::size_class_t  free_q_class,
    input  heap_pkg::block_idx_t   alloc_q_block,
    input  heap_pkg::block_idx_t   free_q_block,
    output logic                   q_push,
    output heap_pkg::size_class_t  q_class,
    output heap_pkg::block_idx_t   q_block
);
    import heap_pkg::*;

    localparam int WORDS =
        `HEAP_PAGE_COUNT * `HEAP_BLOCKS_PER_PAGE / `HEAP_BITMAP_WORD_BITS;

    bitmap_word_t ram [WORDS];
    bitmap_addr_t addr;
    bitmap_word_t wdata;
    logic         we;
    logic         last_free;

    // --------------------------------------------------
    // four-phase grant, round robin on contention
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_ack <= 1'b0;
            free_ack <= 1'b0;
            last_free <= 1'b0;
        end else if (alloc_ack) begin
            if (!alloc_req) begin
                alloc_ack <= 1'b0;
            end
        end else if (free_ack) begin
            if (!free_req) begin
                free_ack <= 1'b0;
            end
        end else if (alloc_req && (!free_req || last_free)) begin
            alloc_ack <= 1'b1;
            last_free <= 1'b0;
        end else if (free_req) begin
            free_ack <= 1'b1;
            last_free <= 1'b1;
        end
    end

    // granted engine owns the bitmap and the push port
    assign addr = free_ack ? free_bm_addr : alloc_bm_addr;
    assign wdata = free_ack ? free_bm_wdata : alloc_bm_wdata;
    assign we = (free_ack && free_bm_we) || (alloc_ack && alloc_bm_we);

    assign q_push = (free_ack && free_q_push) || (alloc_ack && alloc_q_push);
    assign q_class = free_ack ? free_q_class : alloc_q_class;
    assign q_block = free_ack ? free_q_block : alloc_q_block;

    // --------------------------------------------------
    // bitmap RAM, read data one cycle after the address
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (we) begin
            ram[addr] <= wdata;
        end
        bm_rdata <= ram[addr];
    end

endmodule

// File: logic/alloc_engine.sv
`timescale 1ns/1ps
`include "heap_defs.svh"

module alloc_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   init_done,
    input  logic [15:0]            alloc_req_size,
    input  logic                   alloc_req_valid,
    output logic                   alloc_req_ready,
    output logic [31:0]            alloc_rsp_pointer,
    output logic                   alloc_rsp_failed,
    output logic                   alloc_rsp_valid,
    input  logic                   alloc_rsp_ready,
    output logic                   arb_req,
    input  logic                   arb_ack,
    output heap_pkg::bitmap_addr_t bm_addr,
    output logic                   bm_we,
    output heap_pkg::bitmap_word_t bm_wdata,
    input  heap_pkg::bitmap_word_t bm_rdata,
    output logic                   q_push,
    output heap_pkg::size_class_t  q_class,
    output heap_pkg::block_idx_t   q_block,
    output logic                   pop,
    output heap_pkg::size_class_t  pop_class,
    input  heap_pkg::block_idx_t   pop_block,
    input  logic [3:0]             nonempty
);
    import heap_pkg::*;

    localparam logic [2:0]
        S_ACCEPT  = 3'd0,
        S_CHOOSE  = 3'd1,
        S_ACQUIRE = 3'd2,
        S_READ    = 3'd3,
        S_WRITE   = 3'd4,
        S_PUSH    = 3'd5,
        S_RELEASE = 3'd6,
        S_RESPOND = 3'd7;

    logic [2:0]   state;
    size_class_t  req_class;
    size_class_t  in_class;
    logic         in_over;
    block_idx_t   blk;
    logic         split;
    logic [2:0]   split_cnt;
    logic [3:0]   nblk;
    logic [3:0]   piece_off;
    logic         have_own;
    logic         can_split;
    bitmap_word_t mask;

    always_comb begin
        in_class = class_of_bytes(alloc_req_size, in_over);
    end

    assign nblk = blocks_of_class(req_class);
    assign piece_off = split_cnt * nblk;
    assign mask = ((32'd1 << nblk) - 32'd1) << blk[4:0];

    assign have_own = nonempty[req_class];
    // a small class may fall back to breaking up a page
    assign can_split = req_class != CLASS_PAGE && nonempty[CLASS_PAGE];

    assign alloc_req_ready = state == S_ACCEPT && init_done;
    assign pop = state == S_CHOOSE && (have_own || can_split);
    assign pop_class = have_own ? req_class : CLASS_PAGE;

    assign bm_addr = blk[6:5];
    assign bm_we = state == S_WRITE;
    assign bm_wdata = bm_rdata & ~mask;

    // remainders go to the tail of the requested class
    assign q_push = state == S_PUSH;
    assign q_class = req_class;
    assign q_block = blk + piece_off;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_ACCEPT;
            arb_req <= 1'b0;
            alloc_rsp_valid <= 1'b0;
        end else begin
            case (state)
                S_ACCEPT: begin
                    if (alloc_req_valid && alloc_req_ready) begin
                        req_class <= in_class;
                        if (in_over) begin
                            alloc_rsp_pointer <= '0;
                            alloc_rsp_failed <= 1'b1;
                            alloc_rsp_valid <= 1'b1;
                            state <= S_RESPOND;
                        end else begin
                            state <= S_CHOOSE;
                        end
                    end
                end
                S_CHOOSE: begin
                    if (have_own || can_split) begin
                        blk <= pop_block;
                        split <= !have_own;
                        split_cnt <= 3'd1;
                        arb_req <= 1'b1;
                        state <= S_ACQUIRE;
                    end else begin
                        alloc_rsp_pointer <= '0;
                        alloc_rsp_failed <= 1'b1;
                        alloc_rsp_valid <= 1'b1;
                        state <= S_RESPOND;
                    end
                end
                S_ACQUIRE: begin
                    if (arb_ack) begin
                        state <= S_READ;
                    end
                end
                S_READ: state <= S_WRITE;
                S_WRITE: begin
                    if (split) begin
                        state <= S_PUSH;
                    end else begin
                        arb_req <= 1'b0;
                        state <= S_RELEASE;
                    end
                end
                S_PUSH: begin
                    split_cnt <= split_cnt + 1'b1;
                    if (piece_off + nblk == `HEAP_BLOCKS_PER_PAGE) begin
                        arb_req <= 1'b0;
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (!arb_ack) begin
                        alloc_rsp_pointer <= `HEAP_DATA_BASE + 32'(blk) * `HEAP_BLOCK_BYTES;
                        alloc_rsp_failed <= 1'b0;
                        alloc_rsp_valid <= 1'b1;
                        state <= S_RESPOND;
                    end
                end
                default: begin
                    if (alloc_rsp_ready) begin
                        alloc_rsp_valid <= 1'b0;
                        state <= S_ACCEPT;
                    end
                end
            endcase
        end
    end

endmodule

// File: logic/free_engine.sv
`timescale 1ns/1ps
`include "heap_defs.svh"

module free_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            free_pointer,
    input  logic [15:0]            free_size,
    input  logic                   free_valid,
    output logic                   free_ready,
    output logic                   free_error,
    output logic                   init_done,
    output logic                   arb_req,
    input  logic                   arb_ack,
    output heap_pkg::bitmap_addr_t bm_addr,
    output logic                   bm_we,
    output heap_pkg::bitmap_word_t bm_wdata,
    input  heap_pkg::bitmap_word_t bm_rdata,
    output logic                   q_push,
    output heap_pkg::size_class_t  q_class,
    output heap_pkg::block_idx_t   q_block
);
    import heap_pkg::*;

    localparam int HEAP_BYTES =
        `HEAP_PAGE_COUNT * `HEAP_BLOCKS_PER_PAGE * `HEAP_BLOCK_BYTES;

    localparam logic [3:0]
        S_INIT_ACQ  = 4'd0,
        S_INIT_WORD = 4'd1,
        S_INIT_PAGE = 4'd2,
        S_INIT_REL  = 4'd3,
        S_IDLE      = 4'd4,
        S_CHECK     = 4'd5,
        S_ACQUIRE   = 4'd6,
        S_READ      = 4'd7,
        S_TEST      = 4'd8,
        S_WRITE     = 4'd9,
        S_RELEASE   = 4'd10,
        S_DONE      = 4'd11;

    logic [3:0]   state;
    logic [1:0]   word_cnt;
    logic [3:0]   page_cnt;
    logic         in_init;
    logic         rejected;
    logic [31:0]  f_pointer;
    size_class_t  f_class;
    logic         f_over;
    size_class_t  in_class;
    logic         in_over;
    logic [31:0]  f_off;
    block_idx_t   f_blk;
    logic [3:0]   f_nblk;
    bitmap_word_t f_mask;
    logic         range_bad;
    logic         align_bad;

    always_comb begin
        in_class = class_of_bytes(free_size, in_over);
    end

    assign f_off = f_pointer - `HEAP_DATA_BASE;
    assign f_blk = block_idx_t'(f_off / `HEAP_BLOCK_BYTES);
    assign f_nblk = blocks_of_class(f_class);
    assign f_mask = ((32'd1 << f_nblk) - 32'd1) << f_blk[4:0];

    assign range_bad = f_over || f_pointer < `HEAP_DATA_BASE || f_off >= HEAP_BYTES;
    // a piece starts on a multiple of its own size
    assign align_bad = (f_off % `HEAP_BLOCK_BYTES) != 0 || (f_blk & (f_nblk - 1'b1)) != 0;

    assign in_init = state < S_IDLE;
    assign bm_addr = in_init ? word_cnt : f_blk[6:5];
    assign bm_we = state == S_INIT_WORD || state == S_WRITE;
    assign bm_wdata = in_init ? '1 : (bm_rdata | f_mask);
    assign q_push = state == S_INIT_PAGE || state == S_WRITE;
    assign q_class = in_init ? CLASS_PAGE : f_class;
    assign q_block = in_init ? block_idx_t'(page_cnt * `HEAP_BLOCKS_PER_PAGE) : f_blk;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_INIT_ACQ;
            word_cnt <= '0;
            page_cnt <= '0;
            arb_req <= 1'b0;
            init_done <= 1'b0;
            free_ready <= 1'b0;
            free_error <= 1'b0;
            rejected <= 1'b0;
        end else begin
            case (state)
                // --------------------------------------------------
                // start-up: mark everything free, queue all pages
                // --------------------------------------------------
                S_INIT_ACQ: begin
                    arb_req <= 1'b1;
                    if (arb_ack) begin
                        state <= S_INIT_WORD;
                    end
                end
                S_INIT_WORD: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == 2'd3) begin
                        state <= S_INIT_PAGE;
                    end
                end
                S_INIT_PAGE: begin
                    page_cnt <= page_cnt + 1'b1;
                    if (page_cnt == `HEAP_PAGE_COUNT - 1) begin
                        arb_req <= 1'b0;
                        state <= S_INIT_REL;
                    end
                end
                S_INIT_REL: begin
                    if (!arb_ack) begin
                        init_done <= 1'b1;
                        free_ready <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                // --------------------------------------------------
                // free path
                // --------------------------------------------------
                S_IDLE: begin
                    if (free_valid && free_ready) begin
                        f_pointer <= free_pointer;
                        f_class <= in_class;
                        f_over <= in_over;
                        free_ready <= 1'b0;
                        state <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    rejected <= range_bad || align_bad;
                    if (range_bad || align_bad) begin
                        state <= S_RELEASE;
                    end else begin
                        arb_req <= 1'b1;
                        state <= S_ACQUIRE;
                    end
                end
                S_ACQUIRE: begin
                    if (arb_ack) begin
                        state <= S_READ;
                    end
                end
                S_READ: state <= S_TEST;
                S_TEST: begin
                    // any block already free means a double free
                    if ((bm_rdata & f_mask) != 0) begin
                        rejected <= 1'b1;
                        arb_req <= 1'b0;
                        state <= S_RELEASE;
                    end else begin
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    arb_req <= 1'b0;
                    state <= S_RELEASE;
                end
                S_RELEASE: begin
                    if (!arb_ack) begin
                        free_error <= rejected;
                        state <= S_DONE;
                    end
                end
                default: begin
                    free_error <= 1'b0;
                    free_ready <= 1'b1;
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/heap_allocator_top.sv
`timescale 1ns/1ps

module heap_allocator_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] alloc_req_size,
    input  logic        alloc_req_valid,
    output logic        alloc_req_ready,
    output logic [31:0] alloc_rsp_pointer,
    output logic        alloc_rsp_failed,
    output logic        alloc_rsp_valid,
    input  logic        alloc_rsp_ready,
    input  logic [31:0] free_pointer,
    input  logic [15:0] free_size,
    input  logic        free_valid,
    output logic        free_ready,
    output logic        free_error,
    output logic        init_done
);
    import heap_pkg::*;

    logic         alloc_req;
    logic         alloc_ack;
    logic         free_req;
    logic         free_ack;
    bitmap_addr_t alloc_bm_addr;
    bitmap_addr_t free_bm_addr;
    logic         alloc_bm_we;
    logic         free_bm_we;
    bitmap_word_t alloc_bm_wdata;
    bitmap_word_t free_bm_wdata;
    bitmap_word_t bm_rdata;
    logic         alloc_q_push;
    logic         free_q_push;
    size_class_t  alloc_q_class;
    size_class_t  free_q_class;
    block_idx_t   alloc_q_block;
    block_idx_t   free_q_block;
    logic         q_push;
    size_class_t  q_class;
    block_idx_t   q_block;
    logic         pop;
    size_class_t  pop_class;
    block_idx_t   pop_block;
    logic [3:0]   nonempty;

    alloc_engine u_alloc (
        .clk, .rst, .init_done,
        .alloc_req_size, .alloc_req_valid, .alloc_req_ready,
        .alloc_rsp_pointer, .alloc_rsp_failed, .alloc_rsp_valid, .alloc_rsp_ready,
        .arb_req(alloc_req), .arb_ack(alloc_ack),
        .bm_addr(alloc_bm_addr), .bm_we(alloc_bm_we), .bm_wdata(alloc_bm_wdata),
        .bm_rdata,
        .q_push(alloc_q_push), .q_class(alloc_q_class), .q_block(alloc_q_block),
        .pop, .pop_class, .pop_block, .nonempty
    );

    free_engine u_free (
        .clk, .rst,
        .free_pointer, .free_size, .free_valid, .free_ready, .free_error, .init_done,
        .arb_req(free_req), .arb_ack(free_ack),
        .bm_addr(free_bm_addr), .bm_we(free_bm_we), .bm_wdata(free_bm_wdata),
        .bm_rdata,
        .q_push(free_q_push), .q_class(free_q_class), .q_block(free_q_block)
    );

    bitmap_arbiter u_arb (
        .clk, .rst,
        .alloc_req, .alloc_ack, .free_req, .free_ack,
        .alloc_bm_addr, .free_bm_addr, .alloc_bm_we, .free_bm_we,
        .alloc_bm_wdata, .free_bm_wdata, .bm_rdata,
        .alloc_q_push, .free_q_push, .alloc_q_class, .free_q_class,
        .alloc_q_block, .free_q_block,
        .q_push, .q_class, .q_block
    );

    class_queues u_queues (
        .clk, .rst,
        .push(q_push), .push_class(q_class), .push_block(q_block),
        .pop, .pop_class, .pop_block, .nonempty
    );

endmodule

// File: verification/heap_allocator_props.sv
`timescale 1ns/1ps

module heap_allocator_props (
    input logic        clk,
    input logic        rst,
    input logic        alloc_req_ready,
    input logic [31:0] alloc_rsp_pointer,
    input logic        alloc_rsp_failed,
    input logic        alloc_rsp_valid,
    input logic        alloc_rsp_ready,
    input logic        free_ready,
    input logic        free_error,
    input logic        init_done
);

    // response holds while the consumer stalls
    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        alloc_rsp_valid && !alloc_rsp_ready |=>
            alloc_rsp_valid && $stable(alloc_rsp_pointer) && $stable(alloc_rsp_failed))
        else $error("alloc response changed while stalled");

    a_ready_after_init: assert property (@(posedge clk) disable iff (rst)
        !init_done |-> !alloc_req_ready && !free_ready)
        else $error("ready raised before init_done");

    a_error_pulse: assert property (@(posedge clk) disable iff (rst)
        free_error |=> !free_error)
        else $error("free_error longer than one cycle");

endmodule

bind heap_allocator_top heap_allocator_props u_props (
    .clk(clk), .rst(rst),
    .alloc_req_ready(alloc_req_ready),
    .alloc_rsp_pointer(alloc_rsp_pointer), .alloc_rsp_failed(alloc_rsp_failed),
    .alloc_rsp_valid(alloc_rsp_valid), .alloc_rsp_ready(alloc_rsp_ready),
    .free_ready(free_ready), .free_error(free_error), .init_done(init_done)
);

// File: verification/heap_allocator_tests.svh
`ifndef HEAP_ALLOCATOR_TESTS_SVH
`define HEAP_ALLOCATOR_TESTS_SVH

// --------------------------------------------------
// directed tests
// --------------------------------------------------

// whole pages come out in queue order, then the heap is empty
task automatic test_page_alloc();
    logic [31:0] ptr;
    logic        failed;
    begin_test("page_alloc");
    for (int i = 0; i < 16; i++) begin
        alloc_bytes(16'd512, ptr, failed);
        check("page failed", 1'b0, failed);
        check("page pointer", `HEAP_DATA_BASE + i * 512, ptr);
    end
    alloc_bytes(16'd512, ptr, failed);
    check("overflow failed", 1'b1, failed);
    check("overflow pointer", 32'd0, ptr);
    end_test();
endtask

task automatic test_split();
    logic [31:0] ptr;
    logic        failed;
    begin_test("split");
    for (int i = 0; i < 9; i++) begin
        alloc_bytes(16'd64, ptr, failed);
        check("split failed", 1'b0, failed);
        check("split pointer", block_pointer(i), ptr);
    end
    end_test();
endtask

// a freed piece goes to the tail of its queue
task automatic test_reuse();
    logic [31:0] ptr;
    logic        failed;
    logic        err;
    int          expected_blk [4] = '{2, 4, 6, 0};
    begin_test("reuse");
    alloc_bytes(16'd128, ptr, failed);
    check("first pointer", block_pointer(0), ptr);
    free_block(ptr, 16'd128, err);
    check("free error", 1'b0, err);
    for (int i = 0; i < 4; i++) begin
        alloc_bytes(16'd128, ptr, failed);
        check("reuse failed", 1'b0, failed);
        check("reuse pointer", block_pointer(expected_blk[i]), ptr);
    end
    end_test();
endtask

task automatic test_reject();
    logic [31:0] ptr;
    logic        failed;
    logic        err;
    begin_test("reject");
    alloc_bytes(16'd64, ptr, failed);
    check("first pointer", block_pointer(0), ptr);
    // block 5 still sits in the class queue, so it is already free
    free_block(block_pointer(5), 16'd64, err);
    check("double free error", 1'b1, err);
    free_block(block_pointer(1), 16'd128, err);
    check("class misaligned error", 1'b1, err);
    free_block(block_pointer(0) + 32'd32, 16'd64, err);
    check("byte misaligned error", 1'b1, err);
    free_block(block_pointer(128), 16'd64, err);
    check("beyond heap error", 1'b1, err);
    free_block(`HEAP_DATA_BASE - 32'd64, 16'd64, err);
    check("below base error", 1'b1, err);
    for (int i = 1; i < 9; i++) begin
        alloc_bytes(16'd64, ptr, failed);
        check("after reject failed", 1'b0, failed);
        check("after reject pointer", block_pointer(i), ptr);
    end
    end_test();
endtask

task automatic test_backpressure();
    logic [31:0] ptr;
    logic        failed;
    logic [31:0] held_ptr;
    logic        held_failed;
    int          hold;
    begin_test("backpressure");
    hold = 2 + int'(next_random() % 32'd24);
    send_alloc_request(16'd64);
    while (!alloc_rsp_valid) @(negedge clk);
    held_ptr = alloc_rsp_pointer;
    held_failed = alloc_rsp_failed;
    check("held pointer", block_pointer(0), held_ptr);
    check("held failed", 1'b0, held_failed);
    // a second request waits behind the stalled response
    alloc_req_size = 16'd64;
    alloc_req_valid = 1'b1;
    repeat (hold) begin
        @(negedge clk);
        check("stalled valid", 1'b1, alloc_rsp_valid);
        check("stalled pointer", held_ptr, alloc_rsp_pointer);
        check("stalled failed", held_failed, alloc_rsp_failed);
        check("stalled req ready", 1'b0, alloc_req_ready);
    end
    take_alloc_response(ptr, failed);
    check("taken pointer", held_ptr, ptr);
    send_alloc_request(16'd64);
    take_alloc_response(ptr, failed);
    check("second pointer", block_pointer(1), ptr);
    alloc_bytes(16'd600, ptr, failed);
    check("oversize failed", 1'b1, failed);
    check("oversize pointer", 32'd0, ptr);
    end_test();
endtask

`endif

// File: verification/heap_allocator_tb.sv
`timescale 1ns/1ps
`include "heap_defs.svh"

module heap_allocator_tb;

    localparam int TEST_COUNT = 5;
    localparam int CYCLES_PER_TEST = 4000;

    logic        clk;
    logic        rst;
    logic [15:0] alloc_req_size;
    logic        alloc_req_valid;
    logic        alloc_req_ready;
    logic [31:0] alloc_rsp_pointer;
    logic        alloc_rsp_failed;
    logic        alloc_rsp_valid;
    logic        alloc_rsp_ready;
    logic [31:0] free_pointer;
    logic [15:0] free_size;
    logic        free_valid;
    logic        free_ready;
    logic        free_error;
    logic        init_done;

    logic [31:0] rng_state = 32'hd11f_544f;
    string       cur_test;
    int          test_errors_at_start;
    int          tests_run = 0;
    int          check_count = 0;
    int          error_count = 0;

    heap_allocator_top DUT (
        .clk, .rst,
        .alloc_req_size, .alloc_req_valid, .alloc_req_ready,
        .alloc_rsp_pointer, .alloc_rsp_failed, .alloc_rsp_valid, .alloc_rsp_ready,
        .free_pointer, .free_size, .free_valid, .free_ready, .free_error,
        .init_done
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------------------------------------
    // helpers, all of them start and end on a falling edge
    // --------------------------------------------------

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // byte address of a block index
    function automatic logic [31:0] block_pointer(input int blk);
        return `HEAP_DATA_BASE + blk * `HEAP_BLOCK_BYTES;
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s %s: expected %h, got %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst = 1'b1;
        alloc_req_valid = 1'b0;
        alloc_rsp_ready = 1'b0;
        free_valid = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic wait_init();
        while (!init_done) @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errors_at_start = error_count;
        reset_dut();
        // everything idle straight out of reset
        check("reset init_done", 1'b0, init_done);
        check("reset free_ready", 1'b0, free_ready);
        check("reset req ready", 1'b0, alloc_req_ready);
        check("reset rsp valid", 1'b0, alloc_rsp_valid);
        check("reset free_error", 1'b0, free_error);
        wait_init();
        // both input channels open together with init_done
        check("init req ready", 1'b1, alloc_req_ready);
        check("init free_ready", 1'b1, free_ready);
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count == test_errors_at_start) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d errors", cur_test, error_count - test_errors_at_start);
        end
    endtask

    task automatic send_alloc_request(input logic [15:0] size);
        alloc_req_size = size;
        alloc_req_valid = 1'b1;
        while (!alloc_req_ready) @(negedge clk);
        // transfer happens on the next rising edge
        @(negedge clk);
        alloc_req_valid = 1'b0;
    endtask

    task automatic take_alloc_response(output logic [31:0] ptr, output logic failed);
        while (!alloc_rsp_valid) @(negedge clk);
        ptr = alloc_rsp_pointer;
        failed = alloc_rsp_failed;
        alloc_rsp_ready = 1'b1;
        @(negedge clk);
        alloc_rsp_ready = 1'b0;
    endtask

    task automatic alloc_bytes(input logic [15:0] size, output logic [31:0] ptr,
                               output logic failed);
        send_alloc_request(size);
        take_alloc_response(ptr, failed);
    endtask

    // free_ready coming back high ends the free
    task automatic free_block(input logic [31:0] ptr, input logic [15:0] size,
                              output logic error_seen);
        error_seen = 1'b0;
        free_pointer = ptr;
        free_size = size;
        free_valid = 1'b1;
        while (!free_ready) @(negedge clk);
        @(negedge clk);
        free_valid = 1'b0;
        while (!free_ready) begin
            if (free_error) begin
                error_seen = 1'b1;
            end
            @(negedge clk);
        end
    endtask

    `include "heap_allocator_tests.svh"

    initial begin
        rst = 1'b1;
        alloc_req_size = '0;
        alloc_req_valid = 1'b0;
        alloc_rsp_ready = 1'b0;
        free_pointer = '0;
        free_size = '0;
        free_valid = 1'b0;

        test_page_alloc();
        test_split();
        test_reuse();
        test_reject();
        test_backpressure();

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TEST_COUNT * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles",
                 TEST_COUNT * CYCLES_PER_TEST);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: all.f
+incdir+logic
+incdir+verification
logic/heap_pkg.sv
logic/class_queues.sv
logic/bitmap_arbiter.sv
logic/alloc_engine.sv
logic/free_engine.sv
logic/heap_allocator_top.sv
verification/heap_allocator_props.sv
verification/heap_allocator_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = heap_allocator_tb
FILELIST  = all.f
PASS_MSG  = === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
